// File: verilog/hyper_cmd_pkg.sv
// Sizes, register map, enums and packed structs of the HyperBus command path
`default_nettype none

package hyper_cmd_pkg;

   localparam int unsigned NB_CH          = 4;
   localparam int unsigned ID_WIDTH       = 2;
   localparam int unsigned L2_AWIDTH      = 12;
   localparam int unsigned TRANS_SIZE     = 16;
   localparam int unsigned HYPER_AWIDTH   = 32;
   localparam int unsigned CFG_AWIDTH     = 5;
   localparam int unsigned BUFFER_DEPTH   = 4;
   localparam int unsigned FIFO_PTR_WIDTH = $clog2(BUFFER_DEPTH);

   // Channel register word addresses
   typedef enum logic [CFG_AWIDTH-1:0] {
      REG_L2_ADDR    = 5'd0,
      REG_SIZE       = 5'd1,
      REG_HYPER_ADDR = 5'd2,
      REG_STRIDE     = 5'd3,
      REG_ROW_LEN    = 5'd4,
      REG_CTRL       = 5'd5,
      REG_STATUS     = 5'd6
   } cfg_reg_e;

   typedef enum logic {
      HYPER_WRITE = 1'b0,
      HYPER_READ  = 1'b1
   } rw_e;

   typedef enum logic {
      IDLE,
      EMIT
   } split_state_e;

   typedef struct packed {
      logic [CFG_AWIDTH-1:0]   addr;
      logic [31:0]             data;
      logic                    rwn;
   } cfg_req_t;

   typedef struct packed {
      logic [L2_AWIDTH-1:0]    l2_addr;
      logic [TRANS_SIZE-1:0]   size;
      logic [HYPER_AWIDTH-1:0] hyper_addr;
      logic [HYPER_AWIDTH-1:0] stride;
      logic [TRANS_SIZE-1:0]   row_len;
      rw_e                     rw;
   } channel_cmd_t;

   typedef struct packed {
      channel_cmd_t            cmd;
      logic [ID_WIDTH-1:0]     id;
   } tagged_cmd_t;

   typedef struct packed {
      logic [L2_AWIDTH-1:0]    l2_addr;
      logic [HYPER_AWIDTH-1:0] hyper_addr;
      logic [TRANS_SIZE-1:0]   size;
      rw_e                     rw;
      logic [ID_WIDTH-1:0]     id;
      logic                    last;
   } hyper_trans_t;

   typedef struct packed {
      logic                    valid;
      logic [ID_WIDTH-1:0]     id;
   } trans_done_t;

endpackage

`default_nettype wire

// File: verilog/hyper_cmd_queue.sv
// Channel register bank with command issue, busy flag and end-of-transfer event
`timescale 1ns/1ns
`default_nettype none

module hyper_cmd_queue
#(
   parameter int unsigned CH_ID = 0
)
(
   input  logic                                   sys_clk_i,
   input  logic                                   rst_n_i,

   input  hyper_cmd_pkg::cfg_req_t                cfg_req_i,
   input  logic                                   cfg_valid_i,
   output logic                                   cfg_ready_o,
   output logic [31:0]                            cfg_rdata_o,

   output hyper_cmd_pkg::channel_cmd_t            cmd_o,
   output logic                                   cmd_valid_o,
   input  logic                                   cmd_ready_i,

   input  hyper_cmd_pkg::trans_done_t             done_i,
   output logic                                   evt_eot_o,
   output logic                                   busy_o
);

   logic [hyper_cmd_pkg::L2_AWIDTH-1:0]    r_l2_addr;
   logic [hyper_cmd_pkg::TRANS_SIZE-1:0]   r_size;
   logic [hyper_cmd_pkg::HYPER_AWIDTH-1:0] r_hyper_addr;
   logic [hyper_cmd_pkg::HYPER_AWIDTH-1:0] r_stride;
   logic [hyper_cmd_pkg::TRANS_SIZE-1:0]   r_row_len;
   hyper_cmd_pkg::rw_e                     r_rw;
   hyper_cmd_pkg::channel_cmd_t            r_cmd;
   logic                                   r_cmd_valid;
   logic                                   r_busy;
   logic                                   r_eot;
   logic                                   cfg_wr;
   logic                                   start;
   logic                                   own_done;

   assign cfg_wr   = cfg_valid_i & ~cfg_req_i.rwn;
   assign start    = cfg_wr & (cfg_req_i.addr == hyper_cmd_pkg::REG_CTRL)
                     & cfg_req_i.data[0] & ~r_busy;
   assign own_done = done_i.valid & (done_i.id == CH_ID[hyper_cmd_pkg::ID_WIDTH-1:0]);

   ////////////////////
   // Register bank
   always_ff @(posedge sys_clk_i)
   begin
      if (!rst_n_i)
      begin
         r_l2_addr    <= '0;
         r_size       <= '0;
         r_hyper_addr <= '0;
         r_stride     <= '0;
         r_row_len    <= '0;
         r_rw         <= hyper_cmd_pkg::HYPER_WRITE;
      end
      else if (cfg_wr)
      begin
         case (cfg_req_i.addr)
            hyper_cmd_pkg::REG_L2_ADDR:
               r_l2_addr <= cfg_req_i.data[hyper_cmd_pkg::L2_AWIDTH-1:0];
            hyper_cmd_pkg::REG_SIZE:
               r_size <= cfg_req_i.data[hyper_cmd_pkg::TRANS_SIZE-1:0];
            hyper_cmd_pkg::REG_HYPER_ADDR:
               r_hyper_addr <= cfg_req_i.data[hyper_cmd_pkg::HYPER_AWIDTH-1:0];
            hyper_cmd_pkg::REG_STRIDE:
               r_stride <= cfg_req_i.data[hyper_cmd_pkg::HYPER_AWIDTH-1:0];
            hyper_cmd_pkg::REG_ROW_LEN:
               r_row_len <= cfg_req_i.data[hyper_cmd_pkg::TRANS_SIZE-1:0];
            hyper_cmd_pkg::REG_CTRL:
               // Direction is locked while a command runs
               if (!r_busy)
                  r_rw <= hyper_cmd_pkg::rw_e'(cfg_req_i.data[1]);
            default: ;
         endcase
      end
   end

   // Snapshot of the command at start
   always_ff @(posedge sys_clk_i)
   begin
      if (start)
      begin
         r_cmd.l2_addr    <= r_l2_addr;
         r_cmd.size       <= r_size;
         r_cmd.hyper_addr <= r_hyper_addr;
         r_cmd.stride     <= r_stride;
         r_cmd.row_len    <= r_row_len;
         r_cmd.rw         <= hyper_cmd_pkg::rw_e'(cfg_req_i.data[1]);
      end
   end

   ////////////////////
   // Issue and completion
   always_ff @(posedge sys_clk_i)
   begin
      if (!rst_n_i)
      begin
         r_cmd_valid <= 1'b0;
         r_busy      <= 1'b0;
         r_eot       <= 1'b0;
      end
      else
      begin
         r_eot <= own_done;
         if (start)
         begin
            r_cmd_valid <= 1'b1;
            r_busy      <= 1'b1;
         end
         else
         begin
            if (r_cmd_valid && cmd_ready_i)
               r_cmd_valid <= 1'b0;
            if (own_done)
               r_busy <= 1'b0;
         end
      end
   end

   always_comb
   begin
      cfg_rdata_o = '0;
      case (cfg_req_i.addr)
         hyper_cmd_pkg::REG_L2_ADDR:    cfg_rdata_o[hyper_cmd_pkg::L2_AWIDTH-1:0] = r_l2_addr;
         hyper_cmd_pkg::REG_SIZE:       cfg_rdata_o[hyper_cmd_pkg::TRANS_SIZE-1:0] = r_size;
         hyper_cmd_pkg::REG_HYPER_ADDR: cfg_rdata_o[hyper_cmd_pkg::HYPER_AWIDTH-1:0] = r_hyper_addr;
         hyper_cmd_pkg::REG_STRIDE:     cfg_rdata_o[hyper_cmd_pkg::HYPER_AWIDTH-1:0] = r_stride;
         hyper_cmd_pkg::REG_ROW_LEN:    cfg_rdata_o[hyper_cmd_pkg::TRANS_SIZE-1:0] = r_row_len;
         hyper_cmd_pkg::REG_CTRL:       cfg_rdata_o[1] = r_rw;
         hyper_cmd_pkg::REG_STATUS:     cfg_rdata_o[0] = r_busy;
         default: ;
      endcase
   end

   assign cfg_ready_o = 1'b1;
   assign cmd_o       = r_cmd;
   assign cmd_valid_o = r_cmd_valid;
   assign evt_eot_o   = r_eot;
   assign busy_o      = r_busy;

endmodule

`default_nettype wire

// File: verilog/hyper_arbiter.sv
// Round-robin arbiter over channel commands, tagging the winner with its channel id
`timescale 1ns/1ns
`default_nettype none

module hyper_arbiter
(
   input  logic                                              sys_clk_i,
   input  logic                                              rst_n_i,

   input  hyper_cmd_pkg::channel_cmd_t [hyper_cmd_pkg::NB_CH-1:0] cmd_i,
   input  logic [hyper_cmd_pkg::NB_CH-1:0]                   req_i,
   output logic [hyper_cmd_pkg::NB_CH-1:0]                   gnt_o,

   output hyper_cmd_pkg::tagged_cmd_t                        cmd_o,
   output logic                                              req_o,
   input  logic                                              gnt_i
);

   logic [hyper_cmd_pkg::ID_WIDTH-1:0] r_last;
   logic [hyper_cmd_pkg::ID_WIDTH-1:0] win_idx;
   logic                               win_found;

   // First requester after the last winner
   always_comb
   begin
      int unsigned cand;
      win_found = 1'b0;
      win_idx   = r_last;
      for (int unsigned k = 1; k <= hyper_cmd_pkg::NB_CH; k++)
      begin
         cand = (r_last + k) % hyper_cmd_pkg::NB_CH;
         if (!win_found && req_i[cand])
         begin
            win_found = 1'b1;
            win_idx   = cand[hyper_cmd_pkg::ID_WIDTH-1:0];
         end
      end
   end

   always_comb
   begin
      gnt_o = '0;
      if (win_found && gnt_i)
         gnt_o[win_idx] = 1'b1;
   end

   always_comb
   begin
      cmd_o.cmd = cmd_i[win_idx];
      cmd_o.id  = win_idx;
   end

   assign req_o = win_found;

   always_ff @(posedge sys_clk_i)
   begin
      if (!rst_n_i)
         r_last <= '1;
      else if (win_found && gnt_i)
         r_last <= win_idx;
   end

endmodule

`default_nettype wire

// File: verilog/hyper_twd_splitter.sv
// FSM that splits a two-dimensional channel command into one-dimensional transactions
`timescale 1ns/1ns
`default_nettype none

module hyper_twd_splitter
(
   input  logic                          sys_clk_i,
   input  logic                          rst_n_i,

   input  hyper_cmd_pkg::tagged_cmd_t    cmd_i,
   input  logic                          cmd_valid_i,
   output logic                          cmd_ready_o,

   output hyper_cmd_pkg::hyper_trans_t   trans_o,
   output logic                          trans_valid_o,
   input  logic                          trans_ready_i
);

   hyper_cmd_pkg::split_state_e            r_state;
   logic [hyper_cmd_pkg::HYPER_AWIDTH-1:0] r_hyper_addr;
   logic [hyper_cmd_pkg::HYPER_AWIDTH-1:0] r_stride;
   logic [hyper_cmd_pkg::L2_AWIDTH-1:0]    r_l2_addr;
   logic [hyper_cmd_pkg::TRANS_SIZE-1:0]   r_left;
   logic [hyper_cmd_pkg::TRANS_SIZE-1:0]   r_row_len;
   hyper_cmd_pkg::rw_e                     r_rw;
   logic [hyper_cmd_pkg::ID_WIDTH-1:0]     r_id;
   logic [hyper_cmd_pkg::TRANS_SIZE-1:0]   row_size;
   logic                                   last_row;
   logic                                   accept;
   logic                                   emit;

   // Zero row length means one flat transfer
   assign last_row = (r_row_len == '0) || (r_row_len >= r_left);
   assign row_size = last_row ? r_left : r_row_len;

   assign cmd_ready_o   = (r_state == hyper_cmd_pkg::IDLE);
   assign trans_valid_o = (r_state == hyper_cmd_pkg::EMIT);
   assign accept        = cmd_valid_i & cmd_ready_o;
   assign emit          = trans_valid_o & trans_ready_i;

   always_ff @(posedge sys_clk_i)
   begin
      if (!rst_n_i)
         r_state <= hyper_cmd_pkg::IDLE;
      else if (accept)
         r_state <= hyper_cmd_pkg::EMIT;
      else if (emit && last_row)
         r_state <= hyper_cmd_pkg::IDLE;
   end

   ////////////////////
   // Row walk
   always_ff @(posedge sys_clk_i)
   begin
      if (accept)
      begin
         r_hyper_addr <= cmd_i.cmd.hyper_addr;
         r_stride     <= cmd_i.cmd.stride;
         r_l2_addr    <= cmd_i.cmd.l2_addr;
         r_left       <= cmd_i.cmd.size;
         r_row_len    <= cmd_i.cmd.row_len;
         r_rw         <= cmd_i.cmd.rw;
         r_id         <= cmd_i.id;
      end
      else if (emit)
      begin
         r_hyper_addr <= r_hyper_addr + r_stride;
         r_l2_addr    <= r_l2_addr + r_row_len[hyper_cmd_pkg::L2_AWIDTH-1:0];
         r_left       <= r_left - row_size;
      end
   end

   always_comb
   begin
      trans_o.l2_addr    = r_l2_addr;
      trans_o.hyper_addr = r_hyper_addr;
      trans_o.size       = row_size;
      trans_o.rw         = r_rw;
      trans_o.id         = r_id;
      trans_o.last       = last_row;
   end

endmodule

`default_nettype wire

// File: verilog/hyper_trans_fifo.sv
// Synchronous first-word-fall-through FIFO for one-dimensional transactions
`timescale 1ns/1ns
`default_nettype none

module hyper_trans_fifo
(
   input  logic                          sys_clk_i,
   input  logic                          rst_n_i,

   input  hyper_cmd_pkg::hyper_trans_t   push_i,
   input  logic                          push_valid_i,
   output logic                          push_ready_o,

   output hyper_cmd_pkg::hyper_trans_t   pop_o,
   output logic                          pop_valid_o,
   input  logic                          pop_ready_i
);

   hyper_cmd_pkg::hyper_trans_t              mem [hyper_cmd_pkg::BUFFER_DEPTH];
   logic [hyper_cmd_pkg::FIFO_PTR_WIDTH-1:0] r_wr_ptr;
   logic [hyper_cmd_pkg::FIFO_PTR_WIDTH-1:0] r_rd_ptr;
   logic [hyper_cmd_pkg::FIFO_PTR_WIDTH:0]   r_count;
   logic                                     push;
   logic                                     pop;

   assign push_ready_o = (r_count != hyper_cmd_pkg::BUFFER_DEPTH);
   assign pop_valid_o  = (r_count != '0);
   assign push         = push_valid_i & push_ready_o;
   assign pop          = pop_valid_o & pop_ready_i;
   assign pop_o        = mem[r_rd_ptr];

   always_ff @(posedge sys_clk_i)
   begin
      if (push)
         mem[r_wr_ptr] <= push_i;
   end

   always_ff @(posedge sys_clk_i)
   begin
      if (!rst_n_i)
      begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end
      else
      begin
         if (push)
            r_wr_ptr <= (r_wr_ptr == hyper_cmd_pkg::BUFFER_DEPTH - 1) ? '0 : r_wr_ptr + 1'b1;
         if (pop)
            r_rd_ptr <= (r_rd_ptr == hyper_cmd_pkg::BUFFER_DEPTH - 1) ? '0 : r_rd_ptr + 1'b1;
         // Count holds when both sides move
         if (push && !pop)
            r_count <= r_count + 1'b1;
         else if (pop && !push)
            r_count <= r_count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: verilog/hyper_cmd_top.sv
// Top level of the HyperBus command path: channel queues, arbiter, splitter and FIFO
`timescale 1ns/1ns
`default_nettype none

module hyper_cmd_top
(
   input  logic                                        sys_clk_i,
   input  logic                                        rst_n_i,

   input  hyper_cmd_pkg::cfg_req_t                     cfg_req_i,
   input  logic [hyper_cmd_pkg::NB_CH-1:0]             cfg_valid_i,
   output logic [hyper_cmd_pkg::NB_CH-1:0]             cfg_ready_o,
   output logic [hyper_cmd_pkg::NB_CH-1:0][31:0]       cfg_rdata_o,

   output hyper_cmd_pkg::hyper_trans_t                 trans_o,
   output logic                                        trans_valid_o,
   input  logic                                        trans_ready_i,

   output logic [hyper_cmd_pkg::NB_CH-1:0]             evt_eot_o
);

   hyper_cmd_pkg::channel_cmd_t [hyper_cmd_pkg::NB_CH-1:0] ch_cmd;
   logic [hyper_cmd_pkg::NB_CH-1:0]                        ch_cmd_valid;
   logic [hyper_cmd_pkg::NB_CH-1:0]                        ch_cmd_gnt;
   hyper_cmd_pkg::tagged_cmd_t                             twd_cmd;
   logic                                                   twd_valid;
   logic                                                   twd_ready;
   hyper_cmd_pkg::hyper_trans_t                            ond_trans;
   logic                                                   ond_valid;
   logic                                                   ond_ready;
   hyper_cmd_pkg::trans_done_t                             done;

   // Last row leaving the port closes the channel command
   always_comb
   begin
      done.valid = trans_valid_o & trans_ready_i & trans_o.last;
      done.id    = trans_o.id;
   end

   for (genvar i = 0; i < hyper_cmd_pkg::NB_CH; i++)
   begin : gen_ch
      hyper_cmd_queue #(
         .CH_ID ( i )
      ) u_cmd_queue (
         .sys_clk_i   ( sys_clk_i       ),
         .rst_n_i     ( rst_n_i         ),
         .cfg_req_i   ( cfg_req_i       ),
         .cfg_valid_i ( cfg_valid_i[i]  ),
         .cfg_ready_o ( cfg_ready_o[i]  ),
         .cfg_rdata_o ( cfg_rdata_o[i]  ),
         .cmd_o       ( ch_cmd[i]       ),
         .cmd_valid_o ( ch_cmd_valid[i] ),
         .cmd_ready_i ( ch_cmd_gnt[i]   ),
         .done_i      ( done            ),
         .evt_eot_o   ( evt_eot_o[i]    ),
         .busy_o      (                 )
      );
   end

   hyper_arbiter u_arbiter (
      .sys_clk_i ( sys_clk_i    ),
      .rst_n_i   ( rst_n_i      ),
      .cmd_i     ( ch_cmd       ),
      .req_i     ( ch_cmd_valid ),
      .gnt_o     ( ch_cmd_gnt   ),
      .cmd_o     ( twd_cmd      ),
      .req_o     ( twd_valid    ),
      .gnt_i     ( twd_ready    )
   );

   hyper_twd_splitter u_splitter (
      .sys_clk_i     ( sys_clk_i ),
      .rst_n_i       ( rst_n_i   ),
      .cmd_i         ( twd_cmd   ),
      .cmd_valid_i   ( twd_valid ),
      .cmd_ready_o   ( twd_ready ),
      .trans_o       ( ond_trans ),
      .trans_valid_o ( ond_valid ),
      .trans_ready_i ( ond_ready )
   );

   hyper_trans_fifo u_trans_fifo (
      .sys_clk_i    ( sys_clk_i     ),
      .rst_n_i      ( rst_n_i       ),
      .push_i       ( ond_trans     ),
      .push_valid_i ( ond_valid     ),
      .push_ready_o ( ond_ready     ),
      .pop_o        ( trans_o       ),
      .pop_valid_o  ( trans_valid_o ),
      .pop_ready_i  ( trans_ready_i )
   );

endmodule

`default_nettype wire

// File: test/tb_hyper_cmd_asserts.sv
// Bound assertions on the output handshake, end-of-transfer events and reset state
`timescale 1ns/1ns
`default_nettype none

module hyper_cmd_asserts
(
   input  logic                              sys_clk_i,
   input  logic                              rst_n_i,
   input  hyper_cmd_pkg::hyper_trans_t       trans_i,
   input  logic                              trans_valid_i,
   input  logic                              trans_ready_i,
   input  logic [hyper_cmd_pkg::NB_CH-1:0]   eot_i
);

   int unsigned fail_cnt = 0;

   // Stalled transaction holds its contents
   a_trans_stable : assert property (
      @(posedge sys_clk_i) disable iff (!rst_n_i)
      trans_valid_i && !trans_ready_i |=> trans_valid_i && $stable(trans_i)
   ) else
   begin
      $error("trans_o changed while stalled");
      fail_cnt++;
   end

   a_eot_pulse : assert property (
      @(posedge sys_clk_i) disable iff (!rst_n_i)
      (eot_i & $past(eot_i)) == '0
   ) else
   begin
      $error("evt_eot_o high in two consecutive cycles");
      fail_cnt++;
   end

   a_reset_idle : assert property (
      @(posedge sys_clk_i) !rst_n_i |=> !trans_valid_i
   ) else
   begin
      $error("trans_valid_o high right after reset");
      fail_cnt++;
   end

endmodule

bind hyper_cmd_top hyper_cmd_asserts u_asserts (
   .sys_clk_i     ( sys_clk_i     ),
   .rst_n_i       ( rst_n_i       ),
   .trans_i       ( trans_o       ),
   .trans_valid_i ( trans_valid_o ),
   .trans_ready_i ( trans_ready_i ),
   .eot_i         ( evt_eot_o     )
);

`default_nettype wire

// File: test/tb_hyper_cmd.sv
// Testbench for the HyperBus command path: stimulus, split reference, monitor and watchdog
`timescale 1ns/1ns
`default_nettype none

module tb_hyper_cmd;

   localparam int unsigned NCMD = 17;

   logic                                    clk;
   logic                                    rst_n;
   hyper_cmd_pkg::cfg_req_t                 cfg_req;
   logic [hyper_cmd_pkg::NB_CH-1:0]         cfg_valid;
   logic [hyper_cmd_pkg::NB_CH-1:0]         cfg_ready;
   logic [hyper_cmd_pkg::NB_CH-1:0][31:0]   cfg_rdata;
   hyper_cmd_pkg::hyper_trans_t             trans;
   logic                                    trans_valid;
   logic                                    trans_ready;
   logic [hyper_cmd_pkg::NB_CH-1:0]         evt_eot;

   hyper_cmd_pkg::hyper_trans_t             exp_q [hyper_cmd_pkg::NB_CH][$];
   hyper_cmd_pkg::channel_cmd_t             cmds [NCMD];
   int unsigned                             started [hyper_cmd_pkg::NB_CH];
   int unsigned                             eot_cnt [hyper_cmd_pkg::NB_CH];
   logic [31:0]                             lfsr;
   logic                                    rand_ready;
   logic                                    wd_armed;
   int unsigned                             wd_limit;

   hyper_cmd_top hyper_cmd_top_inst (
      .sys_clk_i     ( clk         ),
      .rst_n_i       ( rst_n       ),
      .cfg_req_i     ( cfg_req     ),
      .cfg_valid_i   ( cfg_valid   ),
      .cfg_ready_o   ( cfg_ready   ),
      .cfg_rdata_o   ( cfg_rdata   ),
      .trans_o       ( trans       ),
      .trans_valid_o ( trans_valid ),
      .trans_ready_i ( trans_ready ),
      .evt_eot_o     ( evt_eot     )
   );

   always #2 clk = ~clk;

   // Taps 32 22 2 1
   function automatic logic [31:0] lfsr_bits(input int unsigned n);
      logic [31:0] val;
      logic        fb;
      val = '0;
      for (int unsigned i = 0; i < n; i++)
      begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         val  = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic logic [hyper_cmd_pkg::NB_CH-1:0] ch_mask(input int unsigned ch);
      logic [hyper_cmd_pkg::NB_CH-1:0] m;
      m     = '0;
      m[ch] = 1'b1;
      return m;
   endfunction

   function automatic logic [31:0] reg_mask(input logic [4:0] addr);
      case (addr)
         hyper_cmd_pkg::REG_L2_ADDR: return 32'h0000_0fff;
         hyper_cmd_pkg::REG_SIZE:    return 32'h0000_ffff;
         hyper_cmd_pkg::REG_ROW_LEN: return 32'h0000_ffff;
         default:                    return 32'hffff_ffff;
      endcase
   endfunction

   function automatic int unsigned n_rows(input hyper_cmd_pkg::channel_cmd_t c);
      if (c.row_len == '0 || c.row_len >= c.size)
         return 1;
      return (int'(c.size) + int'(c.row_len) - 1) / int'(c.row_len);
   endfunction

   ////////////////////
   // Reference model
   function automatic void exp_split(input hyper_cmd_pkg::channel_cmd_t c, input int unsigned ch);
      hyper_cmd_pkg::hyper_trans_t          t;
      logic [hyper_cmd_pkg::TRANS_SIZE-1:0] left;
      int unsigned                          k;
      logic                                 fin;
      left = c.size;
      k    = 0;
      fin  = 1'b0;
      while (!fin)
      begin
         t.hyper_addr = c.hyper_addr + k * c.stride;
         t.l2_addr    = c.l2_addr + k * c.row_len;
         t.rw         = c.rw;
         t.id         = ch[hyper_cmd_pkg::ID_WIDTH-1:0];
         if (c.row_len == '0 || c.row_len >= left)
         begin
            t.size = left;
            t.last = 1'b1;
            fin    = 1'b1;
         end
         else
         begin
            t.size = c.row_len;
            t.last = 1'b0;
            left   = left - c.row_len;
         end
         exp_q[ch].push_back(t);
         k++;
      end
   endfunction

   function automatic hyper_cmd_pkg::channel_cmd_t make_cmd(input logic flat);
      hyper_cmd_pkg::channel_cmd_t c;
      c.l2_addr    = 12'(lfsr_bits(12));
      c.hyper_addr = lfsr_bits(32);
      c.stride     = lfsr_bits(16);
      c.size       = 16'(lfsr_bits(7));
      c.row_len    = flat ? '0 : 16'(lfsr_bits(5) + 1);
      c.rw         = hyper_cmd_pkg::rw_e'(1'(lfsr_bits(1)));
      return c;
   endfunction

   task automatic fail_stop();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] want);
      if (got !== want)
      begin
         $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, want);
         fail_stop();
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic cfg_write(input logic [hyper_cmd_pkg::NB_CH-1:0] mask,
                            input logic [4:0] addr, input logic [31:0] data);
      cfg_req   = '{addr: addr, data: data, rwn: 1'b0};
      cfg_valid = mask;
      @(negedge clk);
      check("cfg_ready_o", cfg_ready & mask, mask);
      next_cycle();
      cfg_valid = '0;
   endtask

   task automatic read_check(input int unsigned ch, input logic [4:0] addr,
                             input logic [31:0] want);
      cfg_req   = '{addr: addr, data: '0, rwn: 1'b1};
      cfg_valid = ch_mask(ch);
      @(negedge clk);
      check($sformatf("cfg_rdata_o[%0d] reg %0d", ch, addr), cfg_rdata[ch], want);
      next_cycle();
      cfg_valid = '0;
   endtask

   task automatic setup_cmd(input int unsigned ch, input hyper_cmd_pkg::channel_cmd_t c);
      cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_L2_ADDR, 32'(c.l2_addr));
      cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_SIZE, 32'(c.size));
      cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_HYPER_ADDR, c.hyper_addr);
      cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_STRIDE, c.stride);
      cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_ROW_LEN, 32'(c.row_len));
   endtask

   task automatic arm(input int unsigned ch, input hyper_cmd_pkg::channel_cmd_t c);
      setup_cmd(ch, c);
      exp_split(c, ch);
      started[ch]++;
   endtask

   // Wait for every started command, then idle channels and drained queues
   task automatic finish_all();
      foreach (started[ch])
         while (eot_cnt[ch] != started[ch])
            @(posedge clk);
      next_cycle();
      foreach (started[ch])
      begin
         read_check(ch, hyper_cmd_pkg::REG_STATUS, '0);
         check($sformatf("expected rows left ch%0d", ch), exp_q[ch].size(), 0);
      end
   endtask

   task automatic run_cmd(input int unsigned ch, input hyper_cmd_pkg::channel_cmd_t c);
      arm(ch, c);
      cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_CTRL, {30'b0, c.rw, 1'b1});
      finish_all();
   endtask

   task automatic launch_all(input int unsigned base);
      foreach (started[ch])
         arm(ch, cmds[base + ch]);
      cfg_write('1, hyper_cmd_pkg::REG_CTRL, {30'b0, cmds[base].rw, 1'b1});
   endtask

   ////////////////////
   // Monitor
   always @(negedge clk)
   begin : monitor
      hyper_cmd_pkg::hyper_trans_t want;
      int unsigned                 ch;
      check("assertion failures", hyper_cmd_top_inst.u_asserts.fail_cnt, 0);
      if (rst_n)
      begin
         foreach (eot_cnt[i])
            if (evt_eot[i])
               eot_cnt[i]++;
         if (trans_valid && trans_ready)
         begin
            ch = trans.id;
            if (exp_q[ch].size() == 0)
            begin
               $display("Transaction for channel %0d arrived with none expected", ch);
               fail_stop();
            end
            else
            begin
               want = exp_q[ch].pop_front();
               check("trans_o", trans, want);
            end
         end
      end
   end

   always @(posedge clk)
   begin
      if (rand_ready)
      begin
         #1;
         trans_ready = (lfsr_bits(2) != '0);
      end
   end

   initial
   begin
      wait (wd_armed);
      repeat (wd_limit) @(posedge clk);
      $display("Watchdog expired, run did not finish within %0d cycles", wd_limit);
      fail_stop();
   end

   initial
   begin
      logic [31:0] vals [5];
      int unsigned total;
      clk         = 1'b0;
      rst_n       = 1'b0;
      cfg_req     = '0;
      cfg_valid   = '0;
      trans_ready = 1'b1;
      rand_ready  = 1'b0;
      wd_armed    = 1'b0;
      lfsr        = 32'hb61c;
      total       = 0;
      foreach (started[ch])
      begin
         started[ch] = 0;
         eot_cnt[ch] = 0;
      end
      // Command set with a short final row, a size zero and a long busy command
      cmds[0] = make_cmd(1'b1);
      for (int unsigned i = 1; i < NCMD; i++)
         cmds[i] = make_cmd(1'b0);
      cmds[1].row_len  = 16'd16;
      cmds[1].size     = 16'd53;
      cmds[2].size     = 16'd0;
      cmds[15].row_len = 16'd4;
      cmds[15].size    = 16'd30;
      for (int unsigned i = 8; i < 11; i++)
      begin
         cmds[i].rw     = cmds[7].rw;
         cmds[i + 4].rw = cmds[11].rw;
      end
      for (int unsigned i = 0; i < NCMD - 1; i++)
         total += n_rows(cmds[i]);
      wd_limit = total * 10 + 3000;
      wd_armed = 1'b1;
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Register readback and unmapped addresses
      foreach (started[ch])
      begin
         for (int unsigned a = 0; a < 5; a++)
         begin
            vals[a] = lfsr_bits(32);
            cfg_write(ch_mask(ch), a[4:0], vals[a]);
         end
         cfg_write(ch_mask(ch), 5'd9, lfsr_bits(32));
         cfg_write(ch_mask(ch), hyper_cmd_pkg::REG_CTRL, 32'h2);
         for (int unsigned a = 0; a < 5; a++)
            read_check(ch, a[4:0], vals[a] & reg_mask(a[4:0]));
         read_check(ch, hyper_cmd_pkg::REG_CTRL, 32'h2);
         read_check(ch, 5'd9, '0);
         read_check(ch, 5'd31, '0);
         read_check(ch, hyper_cmd_pkg::REG_STATUS, '0);
      end

      run_cmd(0, cmds[0]);
      for (int unsigned i = 1; i < 7; i++)
         run_cmd(i % hyper_cmd_pkg::NB_CH, cmds[i]);

      launch_all(7);
      finish_all();

      // All channels again under random back-pressure
      rand_ready = 1'b1;
      launch_all(11);
      finish_all();
      rand_ready = 1'b0;
      next_cycle();
      trans_ready = 1'b0;

      // Second start on a busy channel
      arm(2, cmds[15]);
      cfg_write(ch_mask(2), hyper_cmd_pkg::REG_CTRL, {30'b0, cmds[15].rw, 1'b1});
      read_check(2, hyper_cmd_pkg::REG_STATUS, 32'd1);
      setup_cmd(2, cmds[16]);
      cfg_write(ch_mask(2), hyper_cmd_pkg::REG_CTRL, {30'b0, cmds[16].rw, 1'b1});
      read_check(2, hyper_cmd_pkg::REG_STATUS, 32'd1);
      trans_ready = 1'b1;
      finish_all();

      repeat (5) next_cycle();
      foreach (started[ch])
         check($sformatf("evt_eot_o[%0d] count", ch), eot_cnt[ch], started[ch]);
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hyper_cmd.f
verilog/hyper_cmd_pkg.sv
verilog/hyper_cmd_queue.sv
verilog/hyper_arbiter.sv
verilog/hyper_twd_splitter.sv
verilog/hyper_trans_fifo.sv
verilog/hyper_cmd_top.sv
test/tb_hyper_cmd_asserts.sv
test/tb_hyper_cmd.sv

// File: Bender.yml
package:
  name: hyper_cmd

sources:
  - files:
      - verilog/hyper_cmd_pkg.sv
      - verilog/hyper_cmd_queue.sv
      - verilog/hyper_arbiter.sv
      - verilog/hyper_twd_splitter.sv
      - verilog/hyper_trans_fifo.sv
      - verilog/hyper_cmd_top.sv
  - target: test
    files:
      - test/tb_hyper_cmd_asserts.sv
      - test/tb_hyper_cmd.sv
